// ==== compile.f ====
+incdir+src
src/csr_pkg.sv
src/csr_inst_unit.sv
src/csr_regfile.sv
src/excp_unit.sv
src/csr_top.sv
verif/csr_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the CSR testbench with Verilator, runs it and checks the log.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module csr_tb -Mdir obj_dir -f compile.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/Vcsr_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "SOME TESTS FAILED" sim.log; then
    exit 1
fi
exit 0

// ==== src/csr_defines.svh ====
`ifndef CSR_DEFINES_SVH
`define CSR_DEFINES_SVH

// CSR numbers of the kept registers.
`define CSR_CRMD    14'h000
`define CSR_PRMD    14'h001
`define CSR_ESTAT   14'h005
`define CSR_ERA     14'h006
`define CSR_BADV    14'h007
`define CSR_EENTRY  14'h00c
`define CSR_SAVE0   14'h030
`define CSR_SAVE1   14'h031
`define CSR_SAVE2   14'h032
`define CSR_SAVE3   14'h033

// Exception codes.
`define ECODE_INT   6'h00
`define ECODE_ADE   6'h08
`define ECODE_ALE   6'h09
`define ECODE_SYS   6'h0b
`define ECODE_BRK   6'h0c
`define ECODE_INE   6'h0d

`define CRMD_RESET  32'h0000_0008 // Direct address mode, PLV0, interrupts off.

`endif

// ==== src/csr_inst_unit.sv ====
`timescale 1ns/100ps

module csr_inst_unit import csr_pkg::*; (
    input  logic         clk,
    input  logic         rst_n,
    input  logic         inst_valid,
    input  csr_op_e      op,
    input  csr_addr_t    addr,
    input  u32_t         wdata,
    input  u32_t         mask,
    input  u32_t         rd_data,
    output csr_addr_t    rd_addr,
    output inst_wr_req_t wr_req,
    output logic         rsp_valid,
    output u32_t         rsp_data
);

    u32_t merged;

    assign rd_addr = addr; // Old value is read in the strobe cycle.

    // New value for the addressed CSR.
    always_comb begin
        case (op)
            CSR_XCHG: merged = (wdata & mask) | (rd_data & ~mask);
            default:  merged = wdata;
        endcase
    end

    assign wr_req.we   = inst_valid && (op == CSR_WR || op == CSR_XCHG);
    assign wr_req.addr = addr;
    assign wr_req.data = merged;

    // Response strobe, one cycle after the request.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rsp_valid <= 1'b0;
        end else begin
            rsp_valid <= inst_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (inst_valid) begin
            rsp_data <= rd_data; // Every CSR instruction returns the old value.
        end
    end

    a_op_legal: assert property (
        @(posedge clk) disable iff (!rst_n)
        inst_valid |-> op inside {CSR_RD, CSR_WR, CSR_XCHG}
    ) else $error("csr_inst_unit: illegal op %0d", op);

endmodule

// ==== src/csr_pkg.sv ====
package csr_pkg;

    typedef logic [13:0] csr_addr_t;
    typedef logic [31:0] u32_t;
    typedef logic [1:0]  plv_t;
    typedef logic [5:0]  ecode_t;

    // Kind of CSR instruction.
    typedef enum logic [1:0] {
        CSR_RD   = 2'd0,
        CSR_WR   = 2'd1,
        CSR_XCHG = 2'd2 // Masked exchange.
    } csr_op_e;

    typedef struct packed {
        logic [27:0] r0;
        logic        da;  // Direct address translation.
        logic        ie;
        plv_t        plv;
    } crmd_t;

    typedef struct packed {
        logic [28:0] r0;
        logic        pie;
        plv_t        pplv;
    } prmd_t;

    typedef struct packed {
        logic [9:0]  r0_2;
        ecode_t      ecode;
        logic [13:0] r0_1;
        logic [1:0]  swi;  // Software interrupt bits.
    } estat_t;

    // Architectural view of every kept CSR.
    typedef struct packed {
        crmd_t      crmd;
        prmd_t      prmd;
        estat_t     estat;
        u32_t       era;
        u32_t       badv;
        u32_t       eentry;
        u32_t [3:0] save;
    } csr_t;

    typedef struct packed {
        logic      we;
        csr_addr_t addr;
        u32_t      data; // Value after the mask merge.
    } inst_wr_req_t;

    typedef struct packed {
        logic   we;
        plv_t   plv;
        logic   ie;
        plv_t   pplv;
        logic   pie;
        ecode_t ecode;
        u32_t   era;
        u32_t   badv;
        logic   badv_we;
    } excp_wr_req_t;

endpackage

// ==== src/csr_regfile.sv ====
`timescale 1ns/100ps
`include "csr_defines.svh"

module csr_regfile import csr_pkg::*; (
    input  logic         clk,
    input  logic         rst_n,
    input  csr_addr_t    rd_addr,
    input  inst_wr_req_t inst_wr,
    input  excp_wr_req_t excp_wr,
    output u32_t         rd_data,
    output csr_t         csr
);

    // Bits that a CSR instruction may change.
    localparam u32_t CRMD_WMASK   = 32'h0000_000f;
    localparam u32_t PRMD_WMASK   = 32'h0000_0007;
    localparam u32_t ESTAT_WMASK  = 32'h0000_0003; // Only swi, ecode is set by exceptions.
    localparam u32_t EENTRY_WMASK = 32'hffff_ffc0;

    csr_t csr_q;

    function automatic u32_t masked_merge(u32_t old_val, u32_t new_val, u32_t wmask);
        return (old_val & ~wmask) | (new_val & wmask);
    endfunction

    assign csr = csr_q;

    // Read decode.
    always_comb begin
        case (rd_addr)
            `CSR_CRMD:   rd_data = csr_q.crmd;
            `CSR_PRMD:   rd_data = csr_q.prmd;
            `CSR_ESTAT:  rd_data = csr_q.estat;
            `CSR_ERA:    rd_data = csr_q.era;
            `CSR_BADV:   rd_data = csr_q.badv;
            `CSR_EENTRY: rd_data = csr_q.eentry;
            `CSR_SAVE0:  rd_data = csr_q.save[0];
            `CSR_SAVE1:  rd_data = csr_q.save[1];
            `CSR_SAVE2:  rd_data = csr_q.save[2];
            `CSR_SAVE3:  rd_data = csr_q.save[3];
            default:     rd_data = '0; // Unknown CSR reads as zero.
        endcase
    end

    // Exception side wins, the instruction write of the same cycle is lost.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            csr_q      <= '0;
            csr_q.crmd <= crmd_t'(`CRMD_RESET);
        end else if (excp_wr.we) begin
            csr_q.crmd.plv    <= excp_wr.plv;
            csr_q.crmd.ie     <= excp_wr.ie;
            csr_q.prmd.pplv   <= excp_wr.pplv;
            csr_q.prmd.pie    <= excp_wr.pie;
            csr_q.estat.ecode <= excp_wr.ecode;
            csr_q.era         <= excp_wr.era;
            if (excp_wr.badv_we) begin
                csr_q.badv <= excp_wr.badv; // Only for address faults.
            end
        end else if (inst_wr.we) begin
            case (inst_wr.addr)
                `CSR_CRMD: begin
                    csr_q.crmd <= masked_merge(csr_q.crmd, inst_wr.data, CRMD_WMASK);
                end
                `CSR_PRMD: begin
                    csr_q.prmd <= masked_merge(csr_q.prmd, inst_wr.data, PRMD_WMASK);
                end
                `CSR_ESTAT: begin
                    csr_q.estat <= masked_merge(csr_q.estat, inst_wr.data, ESTAT_WMASK);
                end
                `CSR_EENTRY: begin
                    csr_q.eentry <= masked_merge(csr_q.eentry, inst_wr.data, EENTRY_WMASK);
                end
                `CSR_ERA:   csr_q.era     <= inst_wr.data;
                `CSR_BADV:  csr_q.badv    <= inst_wr.data;
                `CSR_SAVE0: csr_q.save[0] <= inst_wr.data;
                `CSR_SAVE1: csr_q.save[1] <= inst_wr.data;
                `CSR_SAVE2: csr_q.save[2] <= inst_wr.data;
                `CSR_SAVE3: csr_q.save[3] <= inst_wr.data;
                default: ; // Writes to unknown CSRs are ignored.
            endcase
        end
    end

    // Neither write path may reach the reserved bits.
    a_rsvd_zero: assert property (
        @(posedge clk) disable iff (!rst_n)
        (csr_q.crmd.r0 == '0) && (csr_q.eentry[5:0] == '0)
    ) else $error("csr_regfile: reserved CRMD or EENTRY bits set");

endmodule

// ==== src/csr_top.sv ====
`timescale 1ns/100ps

module csr_top import csr_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    // CSR instruction port.
    input  logic      inst_valid,
    input  csr_op_e   op,
    input  csr_addr_t addr,
    input  u32_t      wdata,
    input  u32_t      mask,
    output logic      rsp_valid,
    output u32_t      rsp_data,
    // Exception and return port.
    input  logic      excp_valid,
    input  ecode_t    ecode,
    input  u32_t      pc,
    input  u32_t      badv,
    input  logic      badv_valid,
    input  logic      ertn,
    output logic      redirect_valid,
    output u32_t      redirect_pc
);

    csr_addr_t    rd_addr;
    u32_t         rd_data;
    inst_wr_req_t inst_wr;
    excp_wr_req_t excp_wr;
    csr_t         csr;

    csr_inst_unit u_inst (
        .clk(clk), .rst_n(rst_n), .inst_valid(inst_valid), .op(op), .addr(addr),
        .wdata(wdata), .mask(mask), .rd_data(rd_data), .rd_addr(rd_addr),
        .wr_req(inst_wr), .rsp_valid(rsp_valid), .rsp_data(rsp_data)
    );

    csr_regfile u_regfile (
        .clk(clk), .rst_n(rst_n), .rd_addr(rd_addr), .inst_wr(inst_wr),
        .excp_wr(excp_wr), .rd_data(rd_data), .csr(csr)
    );

    excp_unit u_excp (
        .clk(clk), .rst_n(rst_n), .excp_valid(excp_valid), .ecode(ecode), .pc(pc),
        .badv(badv), .badv_valid(badv_valid), .ertn(ertn), .csr(csr),
        .excp_wr(excp_wr), .redirect_valid(redirect_valid), .redirect_pc(redirect_pc)
    );

endmodule

// ==== src/excp_unit.sv ====
`timescale 1ns/100ps

module excp_unit import csr_pkg::*; (
    input  logic         clk,
    input  logic         rst_n,
    input  logic         excp_valid,
    input  ecode_t       ecode,
    input  u32_t         pc,
    input  u32_t         badv,
    input  logic         badv_valid,
    input  logic         ertn,
    input  csr_t         csr,
    output excp_wr_req_t excp_wr,
    output logic         redirect_valid,
    output u32_t         redirect_pc
);

    u32_t target;

    // State swap for entry and return.
    always_comb begin
        excp_wr.we = excp_valid | ertn;
        if (excp_valid) begin
            excp_wr.plv     = 2'd0; // Handler runs at PLV0 with interrupts off.
            excp_wr.ie      = 1'b0;
            excp_wr.pplv    = csr.crmd.plv;
            excp_wr.pie     = csr.crmd.ie;
            excp_wr.ecode   = ecode;
            excp_wr.era     = pc;
            excp_wr.badv    = badv;
            excp_wr.badv_we = badv_valid;
        end else begin
            // Return, everything but plv and ie is written back unchanged.
            excp_wr.plv     = csr.prmd.pplv;
            excp_wr.ie      = csr.prmd.pie;
            excp_wr.pplv    = csr.prmd.pplv;
            excp_wr.pie     = csr.prmd.pie;
            excp_wr.ecode   = csr.estat.ecode;
            excp_wr.era     = csr.era;
            excp_wr.badv    = csr.badv;
            excp_wr.badv_we = 1'b0;
        end
    end

    assign target = excp_valid ? {csr.eentry[31:6], 6'b0} : csr.era;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            redirect_valid <= 1'b0;
        end else begin
            redirect_valid <= excp_valid | ertn;
        end
    end

    always_ff @(posedge clk) begin
        if (excp_valid || ertn) begin
            redirect_pc <= target;
        end
    end

    a_excp_ertn_excl: assert property (
        @(posedge clk) disable iff (!rst_n)
        !(excp_valid && ertn)
    ) else $error("excp_unit: exception and ertn in the same cycle");

endmodule

// ==== verif/csr_tb.sv ====
`timescale 1ns/100ps
`include "csr_defines.svh"

module csr_tb import csr_pkg::*; ();

    // Kept CSRs in shadow slot order, then one unknown number.
    localparam csr_addr_t ADDRS [11] = '{`CSR_CRMD, `CSR_PRMD, `CSR_ESTAT, `CSR_ERA,
        `CSR_BADV, `CSR_EENTRY, `CSR_SAVE0, `CSR_SAVE1, `CSR_SAVE2, `CSR_SAVE3, 14'h3ff};

    logic      clk;
    logic      rst_n;
    logic      inst_valid;
    csr_op_e   op;
    csr_addr_t addr;
    u32_t      wdata;
    u32_t      mask;
    logic      rsp_valid;
    u32_t      rsp_data;
    logic      excp_valid;
    ecode_t    ecode;
    u32_t      pc;
    u32_t      badv;
    logic      badv_valid;
    logic      ertn;
    logic      redirect_valid;
    u32_t      redirect_pc;

    u32_t m_csr [10]; // Shadow copy of the kept CSRs.
    int   inst_slot;
    logic exp_rsp_valid;
    logic exp_redirect_valid;
    u32_t exp_rsp_data;
    u32_t exp_redirect_pc;
    u32_t seed = 32'hb893d74b;
    int   err_count = 0;
    int   test_count = 0;
    int   failed_tests = 0;
    int   test_start_errs = 0;

    csr_top i_csr_top (.*);

    initial clk = 1'b0;
    always #20 clk = ~clk;

    function automatic u32_t xorshift32(u32_t s);
        u32_t x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        return x ^ (x << 5);
    endfunction

    function automatic u32_t next_rand();
        seed = xorshift32(seed);
        return seed;
    endfunction

    function automatic int slot_of(csr_addr_t a);
        for (int i = 0; i < 10; i++) begin
            if (ADDRS[i] == a) begin
                return i;
            end
        end
        return -1;
    endfunction

    // Bits an instruction may change, per slot.
    function automatic u32_t wmask_of(int s);
        case (s)
            0:       return 32'h0000_000f;
            1:       return 32'h0000_0007;
            2:       return 32'h0000_0003;
            5:       return 32'hffff_ffc0;
            default: return 32'hffff_ffff;
        endcase
    endfunction

    function automatic u32_t model_read(int s);
        return (s < 0) ? 32'h0 : m_csr[s];
    endfunction

    function automatic u32_t inst_result(u32_t old_val, int s);
        u32_t new_val;
        new_val = (op == CSR_XCHG) ? ((wdata & mask) | (old_val & ~mask)) : wdata;
        return (old_val & ~wmask_of(s)) | (new_val & wmask_of(s));
    endfunction

    assign inst_slot = slot_of(addr);

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 10; i++) begin
                m_csr[i] <= (i == 0) ? 32'h0000_0008 : 32'h0; // CRMD comes up with DA set.
            end
            exp_rsp_valid      <= 1'b0;
            exp_redirect_valid <= 1'b0;
        end else begin
            exp_rsp_valid      <= inst_valid;
            exp_redirect_valid <= excp_valid | ertn;
            if (inst_valid) begin
                exp_rsp_data <= model_read(inst_slot);
            end
            if (excp_valid) begin
                exp_redirect_pc <= {m_csr[5][31:6], 6'b0};
                m_csr[0] <= {m_csr[0][31:3], 3'b000};         // PLV0, interrupts off.
                m_csr[1] <= {29'b0, m_csr[0][2:0]};
                m_csr[2] <= {m_csr[2][31:22], ecode, m_csr[2][15:0]};
                m_csr[3] <= pc;
                if (badv_valid) begin
                    m_csr[4] <= badv;
                end
            end else if (ertn) begin
                exp_redirect_pc <= m_csr[3];
                m_csr[0] <= {m_csr[0][31:3], m_csr[1][2:0]};
            end else if (inst_valid && op != CSR_RD && inst_slot >= 0) begin
                m_csr[inst_slot] <= inst_result(m_csr[inst_slot], inst_slot);
            end
        end
    end

    task automatic report_mismatch(string name, u32_t got, u32_t exp);
        err_count++;
        $display("Fail %s: got 0x%08h, expected 0x%08h", name, got, exp);
    endtask

    // Outputs are compared midway between rising edges.
    a_rsp_valid: assert property (@(negedge clk) disable iff (!rst_n)
        rsp_valid == exp_rsp_valid)
        else report_mismatch("rsp_valid", {31'b0, rsp_valid}, {31'b0, exp_rsp_valid});
    a_rsp_data: assert property (@(negedge clk) disable iff (!rst_n)
        exp_rsp_valid |-> rsp_data == exp_rsp_data)
        else report_mismatch("rsp_data", rsp_data, exp_rsp_data);
    a_redirect_valid: assert property (@(negedge clk) disable iff (!rst_n)
        redirect_valid == exp_redirect_valid)
        else report_mismatch("redirect_valid", {31'b0, redirect_valid},
                             {31'b0, exp_redirect_valid});
    a_redirect_pc: assert property (@(negedge clk) disable iff (!rst_n)
        exp_redirect_valid |-> redirect_pc == exp_redirect_pc)
        else report_mismatch("redirect_pc", redirect_pc, exp_redirect_pc);

    task automatic wait_valid(bit redirect);
        int n;
        n = 0;
        while (!(redirect ? redirect_valid : rsp_valid) && n < 8) begin
            @(negedge clk);
            n++;
        end
        if (!(redirect ? redirect_valid : rsp_valid)) begin
            err_count++;
            $display("Timeout: no %s pulse within 8 cycles", redirect ? "redirect" : "response");
        end
    endtask

    task automatic drive_inst(csr_op_e o, csr_addr_t a, u32_t d, u32_t m);
        inst_valid = 1'b1;
        op         = o;
        addr       = a;
        wdata      = d;
        mask       = m;
        @(negedge clk);
    endtask

    task automatic csr_access(csr_op_e o, csr_addr_t a, u32_t d, u32_t m);
        drive_inst(o, a, d, m);
        inst_valid = 1'b0;
        wait_valid(1'b0);
    endtask

    task automatic raise_excp(ecode_t c, u32_t p, u32_t b, logic bv);
        excp_valid = 1'b1;
        ecode      = c;
        pc         = p;
        badv       = b;
        badv_valid = bv;
        @(negedge clk);
        excp_valid = 1'b0;
        wait_valid(1'b1);
    endtask

    task automatic return_excp();
        ertn = 1'b1;
        @(negedge clk);
        ertn = 1'b0;
        wait_valid(1'b1);
    endtask

    // Instruction write that collides with an exception strobe.
    task automatic collide(csr_addr_t a, u32_t d, u32_t p);
        excp_valid = 1'b1;
        ecode      = `ECODE_BRK;
        pc         = p;
        badv_valid = 1'b0;
        drive_inst(CSR_WR, a, d, 32'h0);
        inst_valid = 1'b0;
        excp_valid = 1'b0;
        wait_valid(1'b0);
        wait_valid(1'b1);
    endtask

    task automatic read_state();
        for (int i = 0; i < 10; i++) begin
            csr_access(CSR_RD, ADDRS[i], 32'h0, 32'h0);
        end
    endtask

    task automatic finish_test(string name);
        @(negedge clk); // Lets the last check of the test report first.
        test_count++;
        if (err_count != test_start_errs) begin
            failed_tests++;
            $display("Test %s: failed, %0d errors", name, err_count - test_start_errs);
        end else begin
            $display("Test %s: passed", name);
        end
        test_start_errs = err_count;
    endtask

    initial begin
        rst_n      = 1'b0;
        inst_valid = 1'b0;
        op         = CSR_RD;
        addr       = '0;
        wdata      = '0;
        mask       = '0;
        excp_valid = 1'b0;
        ecode      = '0;
        pc         = '0;
        badv       = '0;
        badv_valid = 1'b0;
        ertn       = 1'b0;
        repeat (16) @(negedge clk);
        rst_n = 1'b1;

        for (int i = 0; i < 11; i++) begin
            csr_access(CSR_RD, ADDRS[i], 32'h0, 32'h0);
        end
        finish_test("reset_values");

        // Each read follows its write in the very next cycle.
        for (int i = 0; i < 11; i++) begin
            drive_inst(CSR_WR, ADDRS[i], next_rand(), 32'h0);
            csr_access(CSR_RD, ADDRS[i], 32'h0, 32'h0);
        end
        finish_test("write_read");

        for (int i = 0; i < 11; i++) begin
            csr_access(CSR_WR, ADDRS[i], next_rand(), 32'h0);
            csr_access(CSR_XCHG, ADDRS[i], next_rand(), next_rand());
            csr_access(CSR_RD, ADDRS[i], 32'h0, 32'h0);
        end
        finish_test("exchange");

        csr_access(CSR_WR, `CSR_CRMD, 32'h7, 32'h0); // PLV3 with interrupts on.
        csr_access(CSR_WR, `CSR_EENTRY, next_rand(), 32'h0);
        raise_excp(`ECODE_SYS, next_rand(), next_rand(), 1'b0);
        read_state();
        raise_excp(`ECODE_ADE, next_rand(), next_rand(), 1'b1);
        read_state();
        finish_test("exception_entry");

        csr_access(CSR_WR, `CSR_CRMD, 32'h6, 32'h0);
        raise_excp(`ECODE_INE, next_rand(), 32'h0, 1'b0);
        return_excp();
        read_state();
        csr_access(CSR_WR, `CSR_PRMD, 32'h5, 32'h0);
        csr_access(CSR_WR, `CSR_ERA, next_rand(), 32'h0);
        return_excp();
        read_state();
        finish_test("exception_return");

        collide(`CSR_ERA, next_rand(), next_rand());
        collide(`CSR_SAVE1, next_rand(), next_rand());
        read_state();
        finish_test("write_collision");

        $display("Tests run: %0d, failed: %0d, errors: %0d", test_count, failed_tests,
                 err_count);
        if (err_count == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule
